// File: isaPkg.sv
`default_nettype none

package isaPkg;

    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opBgz   = 4'd2,
        opBlz   = 4'd3,
        opAdi   = 4'd4,
        opOri   = 4'd5,
        opLhi   = 4'd6,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opJal   = 4'd10,
        opRtype = 4'd15
    } opcodeT;

    typedef enum logic [5:0] {
        fnAdd = 6'd0,
        fnSub = 6'd1,
        fnAnd = 6'd2,
        fnOr  = 6'd3,
        fnNot = 6'd4,
        fnTcp = 6'd5,
        fnShl = 6'd6,
        fnShr = 6'd7,
        fnJpr = 6'd25,
        fnJrl = 6'd26,
        fnWwd = 6'd28,
        fnHlt = 6'd29
    } funcT;

    // [15:12] opcode, [11:10] rs, [9:8] rt, [7:6] rd, [5:0] func.
    typedef struct packed {
        opcodeT     opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        funcT       func;
    } instrT;

    localparam int immWidth    = 8;
    localparam int targetWidth = 12;

    localparam logic [1:0] linkReg = 2'd2;

    // immediate and jump target overlay the low fields.
    function automatic logic [immWidth-1:0] immOf(instrT i);
        return {i.rd, i.func};
    endfunction

    function automatic logic [targetWidth-1:0] targetOf(instrT i);
        return {i.rs, i.rt, i.rd, i.func};
    endfunction

endpackage

`default_nettype wire

// File: ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteback,
        stHalted
    } stateT;

    // first eight follow the R-type func codes.
    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluNot   = 4'd4,
        aluTcp   = 4'd5,
        aluShl   = 4'd6,
        aluShr   = 4'd7,
        aluLhi   = 4'd8,
        aluPassB = 4'd9
    } aluOpT;

    typedef struct packed {
        logic  regDst;
        logic  regWrite;
        logic  aluSrc;
        aluOpT aluOp;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  branch;
        logic  jump;
        logic  jumpReg;
        logic  link;
        logic  outWord;
        logic  halt;
    } ctrlT;

    typedef struct packed {
        logic        read;
        logic        write;
        logic [15:0] address;
        logic [15:0] writeData;
    } busReqT;

endpackage

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [15:0]    a,
    input  logic [15:0]    b,
    input  ctrlPkg::aluOpT op,
    output logic [15:0]    result
);

    always_comb begin
        case (op)
            ctrlPkg::aluAdd:   result = a + b;
            ctrlPkg::aluSub:   result = a - b;
            ctrlPkg::aluAnd:   result = a & b;
            ctrlPkg::aluOr:    result = a | b;
            ctrlPkg::aluNot:   result = ~a;
            ctrlPkg::aluTcp:   result = ~a + 16'd1;
            ctrlPkg::aluShl:   result = {a[14:0], 1'b0};
            ctrlPkg::aluShr:   result = {a[15], a[15:1]}; // arithmetic.
            ctrlPkg::aluLhi:   result = {b[7:0], 8'h00};
            ctrlPkg::aluPassB: result = b;
            default:           result = 16'h0000;
        endcase
    end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [1:0]  readAddr1,
    input  logic [1:0]  readAddr2,
    input  logic [1:0]  writeAddr,
    input  logic [15:0] writeData,
    input  logic        writeEn,
    output logic [15:0] readData1,
    output logic [15:0] readData2
);

    logic [15:0] regs [0:3];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= 16'h0000;
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

    // asynchronous reads.
    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

`default_nettype wire

// File: fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
    parameter logic [15:0] resetVector = 16'h0000
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            fetchGo,
    input  logic            pcLoad,
    input  logic [15:0]     nextPc,
    output ctrlPkg::busReqT fetchReq,
    input  logic [15:0]     readData,
    input  logic            fetchAck,
    output logic            fetchDone,
    output logic [15:0]     pc,
    output isaPkg::instrT   instr
);

    // ------------------------------
    // program counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
        end else if (pcLoad) begin
            pc <= nextPc;
        end
    end

    // ------------------------------
    // instruction register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (fetchGo && fetchAck) begin
            instr <= readData; // word valid on the ready edge.
        end
    end

    always_comb begin
        fetchReq           = '0;
        fetchReq.read      = fetchGo;
        fetchReq.address   = pc;
    end

    assign fetchDone = fetchGo & fetchAck;

endmodule

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  logic           clk,
    input  logic           reset,
    input  isaPkg::instrT  instr,
    input  logic           fetchDone,
    input  logic           dataDone,
    output logic           fetchGo,
    output logic           pcLoad,
    output ctrlPkg::stateT state,
    output ctrlPkg::ctrlT  ctrl,
    output logic           halted
);

    ctrlPkg::ctrlT decoded;

    // ------------------------------
    // instruction decode
    // ------------------------------
    always_comb begin
        decoded       = '0;
        decoded.aluOp = ctrlPkg::aluPassB;
        case (instr.opcode)
            isaPkg::opBne, isaPkg::opBeq, isaPkg::opBgz, isaPkg::opBlz: begin
                decoded.branch = 1'b1;
            end
            isaPkg::opAdi, isaPkg::opOri, isaPkg::opLhi: begin
                decoded.regWrite = 1'b1;
                decoded.aluSrc   = 1'b1;
                decoded.aluOp    = (instr.opcode == isaPkg::opAdi) ? ctrlPkg::aluAdd :
                                   (instr.opcode == isaPkg::opOri) ? ctrlPkg::aluOr :
                                                                     ctrlPkg::aluLhi;
            end
            isaPkg::opLwd: begin
                decoded.regWrite = 1'b1;
                decoded.aluSrc   = 1'b1;
                decoded.aluOp    = ctrlPkg::aluAdd; // base plus offset.
                decoded.memRead  = 1'b1;
                decoded.memToReg = 1'b1;
            end
            isaPkg::opSwd: begin
                decoded.aluSrc   = 1'b1;
                decoded.aluOp    = ctrlPkg::aluAdd;
                decoded.memWrite = 1'b1;
            end
            isaPkg::opJmp: begin
                decoded.jump = 1'b1;
            end
            isaPkg::opJal: begin
                decoded.jump     = 1'b1;
                decoded.link     = 1'b1;
                decoded.regWrite = 1'b1;
            end
            isaPkg::opRtype: begin
                case (instr.func)
                    isaPkg::fnAdd, isaPkg::fnSub, isaPkg::fnAnd, isaPkg::fnOr,
                    isaPkg::fnNot, isaPkg::fnTcp, isaPkg::fnShl, isaPkg::fnShr: begin
                        decoded.regDst   = 1'b1;
                        decoded.regWrite = 1'b1;
                        decoded.aluOp    = ctrlPkg::aluOpT'({1'b0, instr.func[2:0]});
                    end
                    isaPkg::fnJpr: decoded.jumpReg = 1'b1;
                    isaPkg::fnJrl: begin
                        decoded.jumpReg  = 1'b1;
                        decoded.link     = 1'b1;
                        decoded.regWrite = 1'b1;
                    end
                    isaPkg::fnWwd: decoded.outWord = 1'b1;
                    isaPkg::fnHlt: decoded.halt = 1'b1;
                    default: ; // unknown func runs as a no-op.
                endcase
            end
            default: ;
        endcase
    end

    // ------------------------------
    // state machine
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ctrlPkg::stFetch;
            ctrl  <= '0;
        end else begin
            case (state)
                ctrlPkg::stFetch: begin
                    if (fetchDone) begin
                        state <= ctrlPkg::stDecode;
                    end
                end
                ctrlPkg::stDecode: begin
                    ctrl  <= decoded; // held until the next decode.
                    state <= ctrlPkg::stExecute;
                end
                ctrlPkg::stExecute: begin
                    if (ctrl.halt) begin
                        state <= ctrlPkg::stHalted;
                    end else if (ctrl.memRead || ctrl.memWrite) begin
                        state <= ctrlPkg::stMemory;
                    end else begin
                        state <= ctrlPkg::stWriteback;
                    end
                end
                ctrlPkg::stMemory: begin
                    if (dataDone) begin
                        state <= ctrlPkg::stWriteback;
                    end
                end
                ctrlPkg::stWriteback: state <= ctrlPkg::stFetch;
                default: state <= ctrlPkg::stHalted; // only reset leaves.
            endcase
        end
    end

    assign fetchGo = (state == ctrlPkg::stFetch);
    assign pcLoad  = (state == ctrlPkg::stExecute);
    assign halted  = (state == ctrlPkg::stHalted);

endmodule

`default_nettype wire

// File: execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  logic            clk,
    input  logic            reset,
    input  ctrlPkg::stateT  state,
    input  ctrlPkg::ctrlT   ctrl,
    input  isaPkg::instrT   instr,
    input  logic [15:0]     pc,
    input  logic [15:0]     loadData,
    input  logic            dataDone,
    output logic [15:0]     nextPc,
    output ctrlPkg::busReqT dataReq,
    output logic [1:0]      regWriteAddr,
    output logic [15:0]     regWriteData,
    output logic            regWriteEn,
    output logic [15:0]     outputData,
    output logic            outputValid
);

    logic [7:0]  imm;
    logic [15:0] rsData;
    logic [15:0] rtData;
    logic [15:0] immSext;
    logic [15:0] aluB;
    logic [15:0] aluResult;
    logic [15:0] pcPlusOne;
    logic [15:0] resultReg;
    logic [15:0] loadWord;
    logic        taken;
    logic        inMemory;

    regFile regFile_i (
        .clk       (clk),
        .reset     (reset),
        .readAddr1 (instr.rs),
        .readAddr2 (instr.rt),
        .writeAddr (regWriteAddr),
        .writeData (regWriteData),
        .writeEn   (regWriteEn),
        .readData1 (rsData),
        .readData2 (rtData)
    );

    assign imm     = isaPkg::immOf(instr);
    assign immSext = {{8{imm[7]}}, imm};
    // ori takes the immediate zero extended.
    assign aluB = !ctrl.aluSrc                   ? rtData :
                  (instr.opcode == isaPkg::opOri) ? {8'h00, imm} : immSext;

    alu alu_i (
        .a      (rsData),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult)
    );

    // ------------------------------
    // branch and next pc
    // ------------------------------
    always_comb begin
        case (instr.opcode)
            isaPkg::opBne: taken = (rsData != rtData);
            isaPkg::opBeq: taken = (rsData == rtData);
            isaPkg::opBgz: taken = ($signed(rsData) > 0);
            isaPkg::opBlz: taken = rsData[15];
            default:       taken = 1'b0;
        endcase
    end

    assign pcPlusOne = pc + 16'd1;

    always_comb begin
        if (ctrl.jumpReg) begin
            nextPc = rsData;
        end else if (ctrl.jump) begin
            nextPc = {pc[15:12], isaPkg::targetOf(instr)}; // stays in the 4K page.
        end else if (ctrl.branch && taken) begin
            nextPc = pcPlusOne + immSext;
        end else begin
            nextPc = pcPlusOne;
        end
    end

    // ------------------------------
    // memory and writeback
    // ------------------------------
    assign inMemory = (state == ctrlPkg::stMemory);

    always_comb begin
        dataReq           = '0;
        dataReq.read      = inMemory & ctrl.memRead;
        dataReq.write     = inMemory & ctrl.memWrite;
        dataReq.address   = aluResult;
        dataReq.writeData = rtData;
    end

    // pc moves at the end of execute, so the link value is kept here.
    always_ff @(posedge clk) begin
        if (state == ctrlPkg::stExecute) begin
            resultReg <= ctrl.link ? pcPlusOne : aluResult;
        end
        if (dataDone) begin
            loadWord <= loadData;
        end
    end

    assign regWriteEn   = (state == ctrlPkg::stWriteback) & ctrl.regWrite;
    assign regWriteAddr = ctrl.link   ? isaPkg::linkReg :
                          ctrl.regDst ? instr.rd : instr.rt;
    assign regWriteData = ctrl.memToReg ? loadWord : resultReg;

    assign outputData  = rsData;
    assign outputValid = (state == ctrlPkg::stExecute) & ctrl.outWord;

endmodule

`default_nettype wire

// File: memAccess.sv
`timescale 1ns/1ps
`default_nettype none

module memAccess (
    input  logic            clk,
    input  logic            reset,
    input  ctrlPkg::busReqT fetchReq,
    input  ctrlPkg::busReqT dataReq,
    input  ctrlPkg::stateT  state,
    output logic            readM,
    output logic            writeM,
    output logic [15:0]     address,
    output logic [15:0]     writeData,
    input  logic            inputReady,
    input  logic            ackOutput,
    output logic            fetchAck,
    output logic            dataDone
);

    ctrlPkg::busReqT sel;
    logic            active;
    logic            busy;
    logic            done;

    assign sel    = (state == ctrlPkg::stMemory) ? dataReq : fetchReq;
    assign active = (state == ctrlPkg::stFetch) | (state == ctrlPkg::stMemory);
    assign busy   = readM | writeM;
    assign done   = (readM & inputReady) | (writeM & ackOutput);

    // ------------------------------
    // strobes
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            readM  <= 1'b0;
            writeM <= 1'b0;
        end else if (done) begin
            readM  <= 1'b0;
            writeM <= 1'b0;
        end else if (!busy && active) begin
            readM  <= sel.read;
            writeM <= sel.write;
        end
    end

    // held steady while a strobe waits.
    always_ff @(posedge clk) begin
        if (!busy) begin
            address   <= sel.address;
            writeData <= sel.writeData;
        end
    end

    assign fetchAck = done & (state == ctrlPkg::stFetch);
    assign dataDone = done & (state == ctrlPkg::stMemory);

endmodule

`default_nettype wire

// File: cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
    parameter logic [15:0] resetVector = 16'h0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic        readM,
    output logic        writeM,
    output logic [15:0] address,
    output logic [15:0] writeData,
    input  logic [15:0] readData,
    input  logic        inputReady,
    input  logic        ackOutput,
    output logic [15:0] outputData,
    output logic        outputValid,
    output logic        halted
);

    logic            fetchGo;
    logic            pcLoad;
    logic            fetchAck;
    logic            fetchDone;
    logic            dataDone;
    logic [15:0]     nextPc;
    logic [15:0]     pc;
    isaPkg::instrT   instr;
    ctrlPkg::stateT  state;
    ctrlPkg::ctrlT   ctrl;
    ctrlPkg::busReqT fetchReq;
    ctrlPkg::busReqT dataReq;

    fetchUnit #(
        .resetVector (resetVector)
    ) fetchUnit_i (
        .clk       (clk),
        .reset     (reset),
        .fetchGo   (fetchGo),
        .pcLoad    (pcLoad),
        .nextPc    (nextPc),
        .fetchReq  (fetchReq),
        .readData  (readData),
        .fetchAck  (fetchAck),
        .fetchDone (fetchDone),
        .pc        (pc),
        .instr     (instr)
    );

    controlUnit controlUnit_i (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .fetchDone (fetchDone),
        .dataDone  (dataDone),
        .fetchGo   (fetchGo),
        .pcLoad    (pcLoad),
        .state     (state),
        .ctrl      (ctrl),
        .halted    (halted)
    );

    // register file sits inside the execute unit.
    execUnit execUnit_i (
        .clk          (clk),
        .reset        (reset),
        .state        (state),
        .ctrl         (ctrl),
        .instr        (instr),
        .pc           (pc),
        .loadData     (readData),
        .dataDone     (dataDone),
        .nextPc       (nextPc),
        .dataReq      (dataReq),
        .regWriteAddr (),
        .regWriteData (),
        .regWriteEn   (),
        .outputData   (outputData),
        .outputValid  (outputValid)
    );

    memAccess memAccess_i (
        .clk        (clk),
        .reset      (reset),
        .fetchReq   (fetchReq),
        .dataReq    (dataReq),
        .state      (state),
        .readM      (readM),
        .writeM     (writeM),
        .address    (address),
        .writeData  (writeData),
        .inputReady (inputReady),
        .ackOutput  (ackOutput),
        .fetchAck   (fetchAck),
        .dataDone   (dataDone)
    );

endmodule

`default_nettype wire

// File: cpuCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore_tb;

    logic        clk = 1'b0;
    logic        reset;
    logic        readM;
    logic        writeM;
    logic [15:0] address;
    logic [15:0] writeData;
    logic [15:0] readData;
    logic        inputReady;
    logic        ackOutput;
    logic [15:0] outputData;
    logic        outputValid;
    logic        halted;

    logic [15:0] mem [0:255];
    logic [15:0] expOut[$];
    logic [15:0] expStoreAddr[$];
    logic [15:0] expStoreData[$];
    logic [15:0] lfsr = 16'd31393;

    int valueErrors = 0;
    int otherErrors = 0;
    int progWords = 0;
    int outCount = 0;
    int storeCount = 0;
    int cycles;
    int limit;
    int waitLeft;
    logic waiting;
    logic haltSeen = 1'b0;

    cpuCore #(
        .resetVector (16'h0000)
    ) cpuCore_i (
        .clk         (clk),
        .reset       (reset),
        .readM       (readM),
        .writeM      (writeM),
        .address     (address),
        .writeData   (writeData),
        .readData    (readData),
        .inputReady  (inputReady),
        .ackOutput   (ackOutput),
        .outputData  (outputData),
        .outputValid (outputValid),
        .halted      (halted)
    );

    always #2 clk = ~clk; // 4 ns period.

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic drawWait(output int w);
        logic [1:0] bits;
        lfsr = lfsrNext(lfsr);
        bits[0] = lfsr[0];
        lfsr = lfsrNext(lfsr);
        bits[1] = lfsr[0];
        w = int'(bits);
    endtask

    task automatic loadStimulus();
        int          fd;
        int          n;
        string       line;
        logic [15:0] a;
        logic [15:0] b;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {i[7:0], ~i[7:0]};
        end
        fd = $fopen("cpuCore_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the stimulus file");
            otherErrors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                a = '0;
                b = '0;
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                case (line[0])
                    "M": begin
                        mem[a[7:0]] = b;
                        progWords++;
                    end
                    "O": expOut.push_back(a);
                    "S": begin
                        expStoreAddr.push_back(a);
                        expStoreData.push_back(b);
                    end
                    default: begin
                        $display("ERROR: unknown stimulus line: %s", line);
                        otherErrors++;
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    task automatic checkStore();
        logic [15:0] ea;
        logic [15:0] ed;
        if (expStoreAddr.size() == 0) begin
            $display("ERROR: unexpected store of %h to %h", writeData, address);
            otherErrors++;
            return;
        end
        ea = expStoreAddr.pop_front();
        ed = expStoreData.pop_front();
        if (address !== ea) begin
            $display("FAILED store[%0d].address: expected %h, actual %h", storeCount, ea, address);
            valueErrors++;
        end
        if (writeData !== ed) begin
            $display("FAILED store[%0d].data: expected %h, actual %h", storeCount, ed, writeData);
            valueErrors++;
        end
        storeCount++;
    endtask

    // ------------------------------
    // memory model
    // ------------------------------
    always @(posedge clk) begin
        #1;
        if (reset) begin
            inputReady = 1'b0;
            ackOutput  = 1'b0;
            waiting    = 1'b0;
        end else if (inputReady || ackOutput) begin
            inputReady = 1'b0; // handshake taken at this edge.
            ackOutput  = 1'b0;
        end else if (readM || writeM) begin
            if (!waiting) begin
                waiting = 1'b1;
                drawWait(waitLeft);
            end
            if (waitLeft == 0) begin
                waiting = 1'b0;
                if (writeM) begin
                    checkStore();
                    mem[address[7:0]] = writeData;
                    ackOutput = 1'b1;
                end else begin
                    readData   = mem[address[7:0]];
                    inputReady = 1'b1;
                end
            end else begin
                waitLeft--;
            end
        end
    end

    // ------------------------------
    // output and halt monitor
    // ------------------------------
    always @(negedge clk) begin
        logic [15:0] exp;
        if (!reset) begin
            if (outputValid) begin
                if (expOut.size() == 0) begin
                    $display("ERROR: unexpected output word %h", outputData);
                    otherErrors++;
                end else begin
                    exp = expOut.pop_front();
                    if (outputData !== exp) begin
                        $display("FAILED output[%0d]: expected %h, actual %h",
                                 outCount, exp, outputData);
                        valueErrors++;
                    end
                end
                outCount++;
            end
            if (haltSeen) begin
                if (!halted) begin
                    $display("ERROR: halted dropped after the core stopped");
                    otherErrors++;
                end
                if (readM || writeM || outputValid) begin
                    $display("ERROR: bus or output activity after halt");
                    otherErrors++;
                end
            end
            if (halted) begin
                haltSeen = 1'b1;
            end
        end
    end

    initial begin
        reset      = 1'b1;
        readData   = 16'h0000;
        inputReady = 1'b0;
        ackOutput  = 1'b0;
        loadStimulus();
        limit = 40 * progWords + 4000;
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        cycles = 0;
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("ERROR: core did not halt within %0d cycles", limit);
            otherErrors++;
        end else begin
            repeat (20) @(posedge clk); // watch the halted core stay quiet.
        end
        if (expOut.size() != 0) begin
            $display("ERROR: %0d expected output words never appeared", expOut.size());
            otherErrors++;
        end
        if (expStoreAddr.size() != 0) begin
            $display("ERROR: %0d expected stores never happened", expStoreAddr.size());
            otherErrors++;
        end
        $display("errors: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cpuCore_stimulus.txt
# M addr word: program image. O word: expected output, in order.
# S addr data: expected store, in order. All values hex.
# arithmetic and logic
M 00 6012
M 01 5034
M 02 41FF
M 03 F1C0
M 04 FC1C
M 05 F1C1
M 06 FC1C
M 07 F1C2
M 08 FC1C
M 09 F1C3
M 0A FC1C
M 0B F0C4
M 0C FC1C
M 0D F0C5
M 0E FC1C
M 0F FCC7
M 10 FC1C
M 11 F0C6
M 12 FC1C
# load and store around base 0080
M 13 6200
M 14 5A80
M 15 8803
M 16 8BFF
M 17 7903
M 18 F41C
M 19 7BFF
M 1A FC1C
# countdown loop, blz untaken then taken, jmp
M 1B 6000
M 1C 4003
M 1D 6100
M 1E F01C
M 1F 40FF
M 20 01FD
M 21 3001
M 22 F01C
M 23 40FF
M 24 3001
M 25 F41C
M 26 9028
M 27 F41C
# jal, jrl, subroutine at 2D returning by jpr, then hlt
M 28 A02D
M 29 6300
M 2A 5F2D
M 2B FC1A
M 2C F01D
M 2D F81C
M 2E F819
O 2467
O 0001
O 1230
O 1237
O EDCB
O EDCC
O F6E6
O 2468
O 1234
O 2468
O 0003
O 0002
O 0001
O 0000
O 0029
O 002C
S 0083 1234
S 007F 2468

// File: cpuCore.f
isaPkg.sv
ctrlPkg.sv
alu.sv
regFile.sv
fetchUnit.sv
controlUnit.sv
execUnit.sv
memAccess.sv
cpuCore.sv
cpuCore_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = cpuCore_tb
FILELIST = cpuCore.f
BUILD    = obj_dir
LOG      = sim.log

SOURCES  = $(shell cat $(FILELIST))
BIN      = $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN) cpuCore_stimulus.txt
	./$(BIN) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
